//--- tracker_pkg.sv
package tracker_pkg;

    typedef logic [11:0] coord_t;            // pixel coordinate or mapped position

    // color windows on the RGB565 fields
    localparam int RED_MIN_R  = 20;
    localparam int RED_MAX_G  = 20;
    localparam int RED_MAX_B  = 10;
    localparam int BLUE_MIN_B = 20;
    localparam int BLUE_MAX_R = 10;
    localparam int BLUE_MAX_G = 20;

    localparam int MIN_PIXELS = 4;           // fewer matches, centroid not trusted
    localparam int CAL_FRAMES = 3;           // frames before origin latch
    localparam coord_t POS_OFFSET = 12'd1800;
    localparam int SUM_W = 30;               // 640 * 480 * 640 fits
    localparam int CNT_W = 19;               // 640 * 480 fits

    typedef union packed {
        struct packed {
            logic [7:0] hi_byte;             // first byte on the bus
            logic [7:0] lo_byte;
        } bytes;
        struct packed {
            logic [4:0] r5;
            logic [5:0] g6;
            logic [4:0] b5;
        } rgb;
    } pixel_word_u;

    typedef struct packed {
        logic        valid;
        coord_t      x;
        coord_t      y;
        pixel_word_u word;
    } pixel_beat_t;

    typedef struct packed {
        logic   valid;
        coord_t x;
        coord_t y;
        logic   is_red;
        logic   is_blue;
    } class_beat_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    typedef struct packed {
        point_t head;                        // red marker
        point_t hand;                        // blue marker
    } frame_result_t;

endpackage

//--- camera_capture.sv
`timescale 1ns/1ps

module camera_capture (
    input wire clk_in,
    input wire rst_in,
    input wire [7:0] cam_data,
    input wire cam_pclk,
    input wire cam_vsync,
    input wire cam_href,
    output logic cam_xclk,
    output logic cam_reset,
    output tracker_pkg::pixel_beat_t pix,
    output logic frame_end
);
    import tracker_pkg::*;

    logic [2:0] pclk_sr;                     // two sync flops plus edge history
    logic [2:0] vsync_sr;
    logic [2:0] href_sr;
    logic [7:0] data_s1, data_s2;            // delayed to line up with pclk_sr[1]
    logic       phase;                       // high once the first byte is held
    coord_t     x_cnt, y_cnt;
    logic [4:0] rst_cnt;

    wire pclk_rise  = pclk_sr[1] & ~pclk_sr[2];
    wire vsync_rise = vsync_sr[1] & ~vsync_sr[2];
    wire href_fall  = ~href_sr[1] & href_sr[2];

    assign cam_reset = ~rst_cnt[4];          // released after 16 cycles

    always_ff @(posedge clk_in) begin
        data_s1 <= cam_data;
        data_s2 <= data_s1;
        pix.valid <= 1'b0;
        frame_end <= 1'b0;
        if (rst_in) begin
            pclk_sr  <= '0;
            vsync_sr <= '0;
            href_sr  <= '0;
            phase    <= 1'b0;
            x_cnt    <= '0;
            y_cnt    <= '0;
            rst_cnt  <= '0;
            cam_xclk <= 1'b0;
        end else begin
            pclk_sr  <= {pclk_sr[1:0], cam_pclk};
            vsync_sr <= {vsync_sr[1:0], cam_vsync};
            href_sr  <= {href_sr[1:0], cam_href};
            cam_xclk <= ~cam_xclk;           // clk_in / 2
            if (!rst_cnt[4]) rst_cnt <= rst_cnt + 5'd1;
            if (vsync_rise) begin
                x_cnt     <= '0;
                y_cnt     <= '0;
                phase     <= 1'b0;
                frame_end <= 1'b1;
            end else if (href_fall) begin    // line done
                x_cnt <= '0;
                y_cnt <= y_cnt + 12'd1;
                phase <= 1'b0;
            end else if (pclk_rise && href_sr[1]) begin
                if (!phase) begin
                    pix.word.bytes.hi_byte <= data_s2;
                    phase <= 1'b1;
                end else begin
                    pix.word.bytes.lo_byte <= data_s2;
                    pix.valid <= 1'b1;
                    pix.x     <= x_cnt;
                    pix.y     <= y_cnt;
                    x_cnt     <= x_cnt + 12'd1;
                    phase     <= 1'b0;
                end
            end
        end
    end

endmodule

//--- color_classifier.sv
`timescale 1ns/1ps

module color_classifier (
    input wire clk_in,
    input wire rst_in,
    input tracker_pkg::pixel_beat_t pix,
    output tracker_pkg::class_beat_t cls
);
    import tracker_pkg::*;

    logic red_hit;
    logic blue_hit;

    // windows cannot overlap since red needs r high and blue needs r low
    always_comb begin
        red_hit  = (pix.word.rgb.r5 >= RED_MIN_R) &&
                   (pix.word.rgb.g6 <= RED_MAX_G) &&
                   (pix.word.rgb.b5 <= RED_MAX_B);
        blue_hit = (pix.word.rgb.b5 >= BLUE_MIN_B) &&
                   (pix.word.rgb.r5 <= BLUE_MAX_R) &&
                   (pix.word.rgb.g6 <= BLUE_MAX_G);
    end

    always_ff @(posedge clk_in) begin
        cls.x       <= pix.x;
        cls.y       <= pix.y;
        cls.is_red  <= red_hit;
        cls.is_blue <= blue_hit;
        if (rst_in) begin
            cls.valid <= 1'b0;
        end else begin
            cls.valid <= pix.valid;          // one stage behind capture
        end
    end

endmodule

//--- centroid_divider.sv
`timescale 1ns/1ps

module centroid_divider (
    input wire clk_in,
    input wire rst_in,
    input wire start,
    input wire [tracker_pkg::SUM_W-1:0] dividend,
    input wire [tracker_pkg::CNT_W-1:0] divisor,
    output tracker_pkg::coord_t quotient,
    output logic done
);
    import tracker_pkg::*;

    localparam int QW = $bits(coord_t);

    logic [CNT_W-1:0] rem;                   // always below divisor between steps
    logic [QW-1:0]    lo_bits;               // dividend bits still to bring down
    logic [3:0]       bit_cnt;
    logic             busy;
    logic [CNT_W:0]   trial;
    logic [CNT_W:0]   diff;
    logic             ge;

    always_comb begin
        trial = {rem, lo_bits[QW-1]};
        diff  = trial - {1'b0, divisor};
        ge    = trial >= {1'b0, divisor};    // zero divisor gives all ones
    end

    always_ff @(posedge clk_in) begin
        done <= 1'b0;
        if (rst_in) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
        end else if (start) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
            rem     <= CNT_W'(dividend[SUM_W-1:QW]); // quotient assumed < 4096
            lo_bits <= dividend[QW-1:0];
        end else if (busy) begin
            rem      <= ge ? diff[CNT_W-1:0] : trial[CNT_W-1:0];
            lo_bits  <= lo_bits << 1;
            quotient <= {quotient[QW-2:0], ge};
            bit_cnt  <= bit_cnt + 4'd1;
            if (bit_cnt == 4'(QW - 1)) begin // last quotient bit
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

endmodule

//--- centroid_tracker.sv
`timescale 1ns/1ps

module centroid_tracker (
    input wire clk_in,
    input wire rst_in,
    input tracker_pkg::class_beat_t cls,
    input wire frame_end,
    output tracker_pkg::frame_result_t result,
    output logic result_valid
);
    import tracker_pkg::*;

    logic [SUM_W-1:0] red_sx, red_sy, blue_sx, blue_sy;          // running sums
    logic [CNT_W-1:0] red_n, blue_n;
    logic [SUM_W-1:0] red_sx_h, red_sy_h, blue_sx_h, blue_sy_h;  // frame snapshot
    logic [CNT_W-1:0] red_n_h, blue_n_h;
    logic [1:0]       idx;                   // hx, hy, bx, by
    logic             start;
    logic             done;
    coord_t           quotient;
    coord_t           q_hx, q_hy, q_bx;
    logic [SUM_W-1:0] dividend;
    logic [CNT_W-1:0] divisor;
    logic             red_ok, blue_ok;

    always_comb begin
        case (idx)
            2'd0:    dividend = red_sx_h;
            2'd1:    dividend = red_sy_h;
            2'd2:    dividend = blue_sx_h;
            default: dividend = blue_sy_h;
        endcase
        divisor = idx[1] ? blue_n_h : red_n_h;
        red_ok  = red_n_h >= CNT_W'(MIN_PIXELS);
        blue_ok = blue_n_h >= CNT_W'(MIN_PIXELS);
    end

    centroid_divider u_div (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .start   (start),
        .dividend(dividend),
        .divisor (divisor),
        .quotient(quotient),
        .done    (done)
    );

    always_ff @(posedge clk_in) begin
        if (frame_end) begin
            {red_sx_h, red_sy_h, red_n_h}    <= {red_sx, red_sy, red_n};
            {blue_sx_h, blue_sy_h, blue_n_h} <= {blue_sx, blue_sy, blue_n};
        end
        if (done) begin
            case (idx)
                2'd0:    q_hx <= quotient;
                2'd1:    q_hy <= quotient;
                2'd2:    q_bx <= quotient;
                default: ;                   // last one goes straight to result
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        start        <= 1'b0;
        result_valid <= 1'b0;
        if (rst_in) begin
            {red_sx, red_sy, red_n}    <= '0;
            {blue_sx, blue_sy, blue_n} <= '0;
            idx    <= '0;
            result <= '0;
        end else begin
            if (frame_end) begin             // snapshot taken, next frame starts clean
                {red_sx, red_sy, red_n}    <= '0;
                {blue_sx, blue_sy, blue_n} <= '0;
                idx   <= '0;
                start <= 1'b1;
            end else if (cls.valid && cls.is_red) begin
                red_sx <= red_sx + SUM_W'(cls.x);
                red_sy <= red_sy + SUM_W'(cls.y);
                red_n  <= red_n + CNT_W'(1);
            end else if (cls.valid && cls.is_blue) begin
                blue_sx <= blue_sx + SUM_W'(cls.x);
                blue_sy <= blue_sy + SUM_W'(cls.y);
                blue_n  <= blue_n + CNT_W'(1);
            end
            if (done) begin
                idx <= idx + 2'd1;
                if (idx != 2'd3) begin
                    start <= 1'b1;
                end else begin
                    if (red_ok) result.head <= {q_hx, q_hy};
                    if (blue_ok) result.hand <= {q_bx, quotient};
                    result_valid <= 1'b1;
                end
            end
        end
    end

endmodule

//--- origin_calibrator.sv
`timescale 1ns/1ps

module origin_calibrator (
    input wire clk_in,
    input wire rst_in,
    input tracker_pkg::frame_result_t result,
    input wire result_valid,
    output tracker_pkg::point_t origin,
    output logic origin_locked
);
    import tracker_pkg::*;

    localparam int FC_W = $clog2(CAL_FRAMES + 1);

    logic [FC_W-1:0] frames;                 // finished frames seen so far

    // early frames let the camera exposure settle before the origin is taken
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            frames        <= '0;
            origin        <= '0;
            origin_locked <= 1'b0;
        end else if (result_valid && !origin_locked) begin
            frames <= frames + FC_W'(1);
            if (frames == FC_W'(CAL_FRAMES - 1)) begin
                origin        <= result.head;  // head of this frame
                origin_locked <= 1'b1;         // sticky until reset
            end
        end
    end

endmodule

//--- position_mapper.sv
`timescale 1ns/1ps

module position_mapper (
    input tracker_pkg::frame_result_t result,
    input tracker_pkg::point_t origin,
    input wire rel_head,
    input wire rel_hand,
    output tracker_pkg::point_t head_pos,
    output tracker_pkg::point_t hand_pos
);
    import tracker_pkg::*;

    // offset space, optionally relative to the origin, wraps at 4096
    function automatic point_t map_point(input point_t p, input point_t org,
                                         input logic rel);
        point_t m;
        m.x = p.x + POS_OFFSET;
        m.y = p.y + POS_OFFSET;
        if (rel) begin
            m.x = m.x - org.x;
            m.y = m.y - org.y;
        end
        // consumer divides by x - offset
        if (m.x == POS_OFFSET) m.x = POS_OFFSET + 12'd1;
        return m;
    endfunction

    always_comb begin
        head_pos = map_point(result.head, origin, rel_head);
        hand_pos = map_point(result.hand, origin, rel_hand);
    end

endmodule

//--- camera_interface.sv
`timescale 1ns/1ps

module camera_interface (
    input wire clk_in,
    input wire rst_in,
    input wire [7:0] cam_data,
    input wire cam_pclk,
    input wire cam_vsync,
    input wire cam_href,
    input wire rel_head,                     // head relative to origin
    input wire rel_hand,                     // hand relative to origin
    output logic cam_xclk,
    output logic cam_reset,
    output tracker_pkg::point_t head_pos,
    output tracker_pkg::point_t hand_pos,
    output logic result_valid,
    output logic origin_locked
);
    import tracker_pkg::*;

    pixel_beat_t   pix;
    class_beat_t   cls;
    logic          frame_end;
    frame_result_t result;
    point_t        origin;

    camera_capture u_capture (
        .clk_in(clk_in), .rst_in(rst_in),
        .cam_data(cam_data), .cam_pclk(cam_pclk),
        .cam_vsync(cam_vsync), .cam_href(cam_href),
        .cam_xclk(cam_xclk), .cam_reset(cam_reset),
        .pix(pix), .frame_end(frame_end)
    );

    color_classifier u_classifier (
        .clk_in(clk_in), .rst_in(rst_in), .pix(pix), .cls(cls)
    );

    centroid_tracker u_tracker (
        .clk_in(clk_in), .rst_in(rst_in), .cls(cls), .frame_end(frame_end),
        .result(result), .result_valid(result_valid)
    );

    origin_calibrator u_calibrator (
        .clk_in(clk_in), .rst_in(rst_in), .result(result),
        .result_valid(result_valid), .origin(origin), .origin_locked(origin_locked)
    );

    position_mapper u_mapper (
        .result(result), .origin(origin), .rel_head(rel_head), .rel_hand(rel_hand),
        .head_pos(head_pos), .hand_pos(hand_pos)
    );

endmodule

//--- tracker_checker.sv
`timescale 1ns/1ps

module tracker_checker (
    input wire clk_in,
    input wire rst_in,
    input wire result_valid,
    input wire origin_locked,
    input wire cam_reset,
    input tracker_pkg::point_t head_pos,
    input tracker_pkg::point_t hand_pos,
    input tracker_pkg::point_t exp_head,
    input tracker_pkg::point_t exp_hand,
    input wire exp_lock,
    input int row_idx,
    output int pass_cnt,
    output int fail_cnt
);
    import tracker_pkg::*;

    int   since_rst;
    logic held_in_reset;                     // cam_reset seen high right after release

    initial begin
        pass_cnt = 0;
        fail_cnt = 0;
        since_rst = 0;
        held_in_reset = 1'b0;
    end

    task automatic report(input string name, input string why);
        if (why == "") begin
            pass_cnt++;
            $display("[PASS] %s", name);
        end else begin
            fail_cnt++;
            $display("[FAIL] t=%0t %s: %s", $time, name, why);
        end
    endtask

    task automatic check_reset();
        string  why;
        point_t idle;
        why = "";
        idle.x = 12'd1801;                   // zero point, offset, x guard
        idle.y = 12'd1800;
        if (!held_in_reset) why = {why, "cam_reset not held after reset; "};
        if (cam_reset !== 1'b0) why = {why, "cam_reset not released; "};
        if (result_valid !== 1'b0) why = {why, "result_valid high; "};
        if (origin_locked !== 1'b0) why = {why, "origin_locked high; "};
        if (head_pos !== idle || hand_pos !== idle) why = {why, "idle positions wrong; "};
        report("reset state", why);
    endtask

    task automatic check_result();
        string why;
        why = "";
        if (head_pos !== exp_head)
            why = {why, $sformatf("head (%0d,%0d) expected (%0d,%0d); ",
                                  head_pos.x, head_pos.y, exp_head.x, exp_head.y)};
        if (hand_pos !== exp_hand)
            why = {why, $sformatf("hand (%0d,%0d) expected (%0d,%0d); ",
                                  hand_pos.x, hand_pos.y, exp_hand.x, exp_hand.y)};
        if (origin_locked !== exp_lock)
            why = {why, $sformatf("origin_locked %b expected %b; ", origin_locked, exp_lock)};
        report($sformatf("frame %0d", row_idx), why);
    endtask

    always @(posedge clk_in) begin
        if (rst_in) begin
            since_rst = 0;
            held_in_reset = 1'b0;
        end else begin
            since_rst = since_rst + 1;
            if (since_rst == 2) held_in_reset = (cam_reset === 1'b1);
            if (since_rst == 20) check_reset();  // camera reset long released
            if (result_valid === 1'b1) check_result();
        end
    end

endmodule

//--- tracker_props.sv
`timescale 1ns/1ps

module tracker_props (
    input wire clk_in,
    input wire rst_in,
    input wire result_valid,
    input wire origin_locked,
    input wire cam_xclk,
    input tracker_pkg::point_t head_pos,
    input tracker_pkg::point_t hand_pos
);
    import tracker_pkg::*;

    int err_cnt = 0;                         // failed assertion count

    a_result_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
        result_valid |=> !result_valid)
        else begin
            $error("result_valid high for more than one cycle");
            err_cnt++;
        end

    a_lock_sticky: assert property (@(posedge clk_in) disable iff (rst_in)
        origin_locked |=> origin_locked)
        else begin
            $error("origin_locked fell without reset");
            err_cnt++;
        end

    a_head_x_guard: assert property (@(posedge clk_in) disable iff (rst_in)
        head_pos.x != POS_OFFSET)
        else begin
            $error("head_pos.x equals the offset");
            err_cnt++;
        end

    a_hand_x_guard: assert property (@(posedge clk_in) disable iff (rst_in)
        hand_pos.x != POS_OFFSET)
        else begin
            $error("hand_pos.x equals the offset");
            err_cnt++;
        end

    // first cycle out of reset still holds the reset value
    a_xclk_toggle: assert property (@(posedge clk_in) disable iff (rst_in)
        !$past(rst_in) |-> cam_xclk != $past(cam_xclk))
        else begin
            $error("cam_xclk missed a toggle");
            err_cnt++;
        end

endmodule

bind camera_interface tracker_props u_props (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .result_valid (result_valid),
    .origin_locked(origin_locked),
    .cam_xclk     (cam_xclk),
    .head_pos     (head_pos),
    .hand_pos     (hand_pos)
);

//--- tb_camera_interface.sv
`timescale 1ns/1ps

module tb_camera_interface;
    import tracker_pkg::*;

    localparam int N_ROWS = 7;
    localparam int FRAME_W = 16;
    localparam int FRAME_H = 8;
    localparam int PCLK_HALF = 4;            // clk_in cycles per pclk level
    localparam int TIMEOUT_CYCLES = N_ROWS * (FRAME_W * FRAME_H * 2 * 2 * PCLK_HALF + 300);

    typedef struct packed {
        logic [3:0] x0;
        logic [3:0] y0;
        logic [3:0] x1;
        logic [3:0] y1;
    } rect_t;

    typedef struct packed {
        logic [15:0] bg;
        logic        noise;                  // lcg background instead of bg
        rect_t       red;
        rect_t       blue;
        logic        rel_head;
        logic        rel_hand;
        point_t      exp_head;
        point_t      exp_hand;
        logic        exp_lock;
    } frame_row_t;

    logic        clk_in, rst_in;
    logic [7:0]  cam_data;
    logic        cam_pclk, cam_vsync, cam_href;
    logic        rel_head, rel_hand;
    logic        cam_xclk, cam_reset;
    point_t      head_pos, hand_pos;
    logic        result_valid, origin_locked;
    point_t      exp_head, exp_hand;
    logic        exp_lock;
    int          row_idx;
    int          pass_cnt, fail_cnt;
    int          cycle_cnt;
    logic [31:0] lcg_state;
    frame_row_t  rows [N_ROWS];

    always #5 clk_in = ~clk_in;

    camera_interface dut (
        .clk_in(clk_in), .rst_in(rst_in),
        .cam_data(cam_data), .cam_pclk(cam_pclk),
        .cam_vsync(cam_vsync), .cam_href(cam_href),
        .rel_head(rel_head), .rel_hand(rel_hand),
        .cam_xclk(cam_xclk), .cam_reset(cam_reset),
        .head_pos(head_pos), .hand_pos(hand_pos),
        .result_valid(result_valid), .origin_locked(origin_locked)
    );

    tracker_checker u_checker (
        .clk_in(clk_in), .rst_in(rst_in),
        .result_valid(result_valid), .origin_locked(origin_locked),
        .cam_reset(cam_reset), .head_pos(head_pos), .hand_pos(hand_pos),
        .exp_head(exp_head), .exp_hand(exp_hand), .exp_lock(exp_lock),
        .row_idx(row_idx), .pass_cnt(pass_cnt), .fail_cnt(fail_cnt)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic in_rect(input rect_t r, input int x, input int y);
        return x >= r.x0 && x <= r.x1 && y >= r.y0 && y <= r.y1;
    endfunction

    function automatic logic [15:0] pick_color(input frame_row_t r, input int x, input int y,
                                               input logic [15:0] bg);
        if (in_rect(r.red, x, y)) return 16'hF800;       // pure red
        if (in_rect(r.blue, x, y)) return 16'h001F;      // pure blue
        return bg;
    endfunction

    // corners x0 y0 x1 y1; centroid is floor of the corner midpoint
    task automatic load_table();
        rows[0] = '{16'h7BCF, 1'b0, '{4'd2, 4'd1, 4'd5, 4'd3}, '{4'd10, 4'd4, 4'd13, 4'd6},
                    1'b0, 1'b0, '{12'd1803, 12'd1802}, '{12'd1811, 12'd1805}, 1'b0};
        rows[1] = '{16'h0000, 1'b0, '{4'd7, 4'd0, 4'd9, 4'd0}, '{4'd0, 4'd6, 4'd3, 4'd7},
                    1'b0, 1'b0, '{12'd1803, 12'd1802}, '{12'd1801, 12'd1806}, 1'b0};
        rows[2] = '{16'h7BCF, 1'b0, '{4'd4, 4'd2, 4'd9, 4'd5}, '{4'd12, 4'd0, 4'd15, 4'd1},
                    1'b0, 1'b0, '{12'd1806, 12'd1803}, '{12'd1813, 12'd1800}, 1'b0};
        rows[3] = '{16'h7BCF, 1'b0, '{4'd8, 4'd4, 4'd11, 4'd7}, '{4'd1, 4'd1, 4'd4, 4'd2},
                    1'b1, 1'b1, '{12'd1803, 12'd1802}, '{12'd1796, 12'd1798}, 1'b1};
        rows[4] = '{16'h0000, 1'b0, '{4'd12, 4'd0, 4'd14, 4'd2}, '{4'd5, 4'd3, 4'd7, 4'd5},
                    1'b0, 1'b1, '{12'd1813, 12'd1801}, '{12'd1801, 12'd1801}, 1'b1};
        rows[5] = '{16'h0000, 1'b1, '{4'd1, 4'd1, 4'd4, 4'd4}, '{4'd9, 4'd3, 4'd14, 4'd6},
                    1'b0, 1'b0, '{12'd1802, 12'd1802}, '{12'd1811, 12'd1804}, 1'b1};
        rows[6] = '{16'h7BCF, 1'b0, '{4'd5, 4'd0, 4'd7, 4'd3}, '{4'd0, 4'd6, 4'd1, 4'd7},
                    1'b1, 1'b1, '{12'd1801, 12'd1798}, '{12'd1794, 12'd1803}, 1'b1};
    endtask

    task automatic tick(input int n);
        repeat (n) @(posedge clk_in);
        #1;
    endtask

    task automatic send_byte(input logic [7:0] b);
        cam_data = b;
        cam_pclk = 1'b0;
        tick(PCLK_HALF);
        cam_pclk = 1'b1;                     // camera samples on this edge
        tick(PCLK_HALF);
    endtask

    task automatic send_frame(input frame_row_t r);
        logic [15:0] bg;
        logic [15:0] px;
        for (int y = 0; y < FRAME_H; y++) begin
            cam_href = 1'b1;
            for (int x = 0; x < FRAME_W; x++) begin
                bg = r.bg;
                if (r.noise) begin
                    lcg_state = lcg_step(lcg_state);
                    bg = lcg_state[30:15] | 16'h0400;  // g6 above both windows
                end
                px = pick_color(r, x, y, bg);
                send_byte(px[15:8]);         // high byte first
                send_byte(px[7:0]);
            end
            cam_href = 1'b0;
            cam_pclk = 1'b0;
            tick(2 * PCLK_HALF);             // line blanking
        end
        cam_vsync = 1'b1;
        tick(2 * PCLK_HALF);
        cam_vsync = 1'b0;
    endtask

    task automatic wait_result();
        do @(posedge clk_in); while (result_valid !== 1'b1);
        #1;
    endtask

    always @(posedge clk_in) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles without all results", cycle_cnt);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        clk_in = 1'b0;
        rst_in = 1'b1;
        cam_data = 8'h00;
        cam_pclk = 1'b0;
        cam_vsync = 1'b0;
        cam_href = 1'b0;
        rel_head = 1'b0;
        rel_hand = 1'b0;
        exp_head = '0;
        exp_hand = '0;
        exp_lock = 1'b0;
        row_idx = 0;
        cycle_cnt = 0;
        lcg_state = 32'd81;
        load_table();
        tick(4);
        rst_in = 1'b0;
        for (int i = 0; i < N_ROWS; i++) begin
            row_idx = i;
            rel_head = rows[i].rel_head;
            rel_hand = rows[i].rel_hand;
            exp_head = rows[i].exp_head;
            exp_hand = rows[i].exp_hand;
            exp_lock = rows[i].exp_lock;
            send_frame(rows[i]);
            wait_result();
        end
        tick(4);
        $display("tests passed: %0d, failed: %0d, assertion failures: %0d",
                 pass_cnt, fail_cnt, dut.u_props.err_cnt);
        if (fail_cnt == 0 && pass_cnt == N_ROWS + 1 && dut.u_props.err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            if (pass_cnt + fail_cnt != N_ROWS + 1)
                $display("only %0d of %0d tests reported", pass_cnt + fail_cnt, N_ROWS + 1);
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
tracker_pkg.sv
camera_capture.sv
color_classifier.sv
centroid_divider.sv
centroid_tracker.sv
origin_calibrator.sv
position_mapper.sv
camera_interface.sv
tracker_checker.sv
tracker_props.sv
tb_camera_interface.sv
